/* flist.f */
hdl/cpu_pkg.sv
hdl/instruction_mem.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/data_mem.sv
hdl/cpu_top.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // widths and sizes
    localparam int ISA_WIDTH       = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int IMEM_DEPTH      = 64;  // words
    localparam int IMEM_ADDR_WIDTH = 6;
    localparam int DMEM_DEPTH      = 64;  // words

    // byte address of the output port, just past the end of data memory
    localparam logic [ISA_WIDTH-1:0] OUT_ADDR = 32'h0000_0100;

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    // r-type function codes
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT   // signed compare
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,  // value read in decode
        FWD_MEM,  // ex/mem alu result
        FWD_WB    // mem/wb write data
    } fwd_sel_t;

    // one instruction word, seen as r-type or i-type
    typedef union packed {
        struct packed {
            logic [5:0]                opcode;
            logic [REG_ADDR_WIDTH-1:0] rs;
            logic [REG_ADDR_WIDTH-1:0] rt;
            logic [REG_ADDR_WIDTH-1:0] rd;
            logic [4:0]                shamt;
            logic [5:0]                funct;
        } r;
        struct packed {
            logic [5:0]                opcode;
            logic [REG_ADDR_WIDTH-1:0] rs;
            logic [REG_ADDR_WIDTH-1:0] rt;
            logic [15:0]               imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       run,        // low while the host loads
    input  wire                       load_req,
    input  wire [IMEM_ADDR_WIDTH-1:0] load_addr,
    input  wire [ISA_WIDTH-1:0]       load_data,
    input  wire                       out_ack,
    output logic                      load_ack,
    output logic                      out_req,
    output logic [ISA_WIDTH-1:0]      out_data
);

    // stall and redirect
    logic                      hazard_stall;
    logic                      out_stall;
    logic                      branch_taken;
    logic [ISA_WIDTH-1:0]      branch_target;
    // if/id
    instr_t                    id_instr;
    logic [ISA_WIDTH-1:0]      id_pc_plus4;
    logic                      id_valid;
    // id/ex
    alu_op_t                   ex_alu_op;
    logic [ISA_WIDTH-1:0]      ex_operand_a, ex_operand_b, ex_imm, ex_pc_plus4;
    logic [REG_ADDR_WIDTH-1:0] ex_rs, ex_rt, ex_dest;
    logic                      ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic                      ex_branch, ex_valid;
    // ex/mem
    logic [ISA_WIDTH-1:0]      mem_result, mem_store_data;
    logic [REG_ADDR_WIDTH-1:0] mem_dest;
    logic                      mem_reg_write, mem_mem_read, mem_mem_write, mem_valid;
    // mem/wb, to register file and forwarding
    logic [ISA_WIDTH-1:0]      wb_data;
    logic [REG_ADDR_WIDTH-1:0] wb_dest;
    logic                      wb_reg_write;

    instruction_mem instruction_mem_i (
        .clk(clk), .arst_n(arst_n), .run(run),
        .load_req(load_req), .load_addr(load_addr), .load_data(load_data),
        .load_ack(load_ack),
        .hazard_stall(hazard_stall), .out_stall(out_stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .id_instr(id_instr), .id_pc_plus4(id_pc_plus4), .id_valid(id_valid)
    );

    decode_stage decode_stage_i (
        .clk(clk), .arst_n(arst_n),
        .id_instr(id_instr), .id_pc_plus4(id_pc_plus4), .id_valid(id_valid),
        .branch_taken(branch_taken), .out_stall(out_stall),
        .wb_data(wb_data), .wb_dest(wb_dest), .wb_reg_write(wb_reg_write),
        .hazard_stall(hazard_stall),
        .ex_alu_op(ex_alu_op), .ex_operand_a(ex_operand_a), .ex_operand_b(ex_operand_b),
        .ex_imm(ex_imm), .ex_use_imm(ex_use_imm),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dest(ex_dest),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_branch(ex_branch),
        .ex_pc_plus4(ex_pc_plus4), .ex_valid(ex_valid)
    );

    execute_stage execute_stage_i (
        .clk(clk), .arst_n(arst_n), .out_stall(out_stall),
        .ex_alu_op(ex_alu_op), .ex_operand_a(ex_operand_a), .ex_operand_b(ex_operand_b),
        .ex_imm(ex_imm), .ex_use_imm(ex_use_imm),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dest(ex_dest),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_branch(ex_branch),
        .ex_pc_plus4(ex_pc_plus4), .ex_valid(ex_valid),
        .wb_data(wb_data), .wb_dest(wb_dest), .wb_reg_write(wb_reg_write),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_dest(mem_dest),
        .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read),
        .mem_mem_write(mem_mem_write), .mem_valid(mem_valid)
    );

    data_mem data_mem_i (
        .clk(clk), .arst_n(arst_n), .out_ack(out_ack),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_dest(mem_dest),
        .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read),
        .mem_mem_write(mem_mem_write), .mem_valid(mem_valid),
        .out_req(out_req), .out_data(out_data), .out_stall(out_stall),
        .wb_data(wb_data), .wb_dest(wb_dest), .wb_reg_write(wb_reg_write)
    );

endmodule

`default_nettype wire

/* hdl/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import cpu_pkg::*; (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       out_ack,
    input  wire [ISA_WIDTH-1:0]       mem_result,      // address or alu value
    input  wire [ISA_WIDTH-1:0]       mem_store_data,
    input  wire [REG_ADDR_WIDTH-1:0]  mem_dest,
    input  wire                       mem_reg_write,
    input  wire                       mem_mem_read,
    input  wire                       mem_mem_write,
    input  wire                       mem_valid,
    output logic                      out_req,
    output logic [ISA_WIDTH-1:0]      out_data,
    output logic                      out_stall,
    output logic [ISA_WIDTH-1:0]      wb_data,
    output logic [REG_ADDR_WIDTH-1:0] wb_dest,
    output logic                      wb_reg_write
);

    logic [ISA_WIDTH-1:0]              dmem [DMEM_DEPTH];
    logic [$clog2(DMEM_DEPTH)-1:0]     word_addr;
    logic [ISA_WIDTH-1:0]              rd_data;
    logic                              to_port;    // store aimed at OUT_ADDR
    logic                              out_start;  // launch output handshake
    logic                              st_mem;     // ordinary store

    assign word_addr = mem_result[$clog2(DMEM_DEPTH)+1:2];
    assign rd_data   = dmem[word_addr];  // async read
    assign to_port   = mem_valid && mem_mem_write && mem_result == OUT_ADDR;
    assign st_mem    = mem_valid && mem_mem_write && mem_result != OUT_ADDR && !out_stall;

    // busy until req dropped and ack released
    assign out_stall = out_req || out_ack;
    assign out_start = to_port && !out_stall;

    always_ff @(posedge clk) begin
        if (st_mem) begin
            dmem[word_addr] <= mem_store_data;
        end
    end

    // output handshake, req falls once ack seen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req <= 1'b0;
        end else if (out_start) begin
            out_req <= 1'b1;
        end else if (out_ack) begin
            out_req <= 1'b0;
        end
    end

    // held for the whole req phase
    always_ff @(posedge clk) begin
        if (out_start) begin
            out_data <= mem_store_data;
        end
    end

    // mem/wb control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_reg_write <= 1'b0;
        end else if (!out_stall) begin
            wb_reg_write <= mem_valid && mem_reg_write;
        end
    end

    // mem/wb payload, load data or alu result
    always_ff @(posedge clk) begin
        if (!out_stall) begin
            wb_data <= mem_mem_read ? rd_data : mem_result;
            wb_dest <= mem_dest;
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire instr_t              id_instr,
    input  wire [ISA_WIDTH-1:0]      id_pc_plus4,
    input  wire                      id_valid,
    input  wire                      branch_taken,  // squash what sits in decode
    input  wire                      out_stall,
    input  wire [ISA_WIDTH-1:0]      wb_data,
    input  wire [REG_ADDR_WIDTH-1:0] wb_dest,
    input  wire                      wb_reg_write,
    output logic                     hazard_stall,
    output alu_op_t                  ex_alu_op,
    output logic [ISA_WIDTH-1:0]     ex_operand_a,  // rs value
    output logic [ISA_WIDTH-1:0]     ex_operand_b,  // rt value
    output logic [ISA_WIDTH-1:0]     ex_imm,
    output logic                     ex_use_imm,
    output logic [REG_ADDR_WIDTH-1:0] ex_rs,
    output logic [REG_ADDR_WIDTH-1:0] ex_rt,
    output logic [REG_ADDR_WIDTH-1:0] ex_dest,
    output logic                     ex_reg_write,
    output logic                     ex_mem_read,
    output logic                     ex_mem_write,
    output logic                     ex_branch,
    output logic [ISA_WIDTH-1:0]     ex_pc_plus4,
    output logic                     ex_valid
);

    logic [ISA_WIDTH-1:0]      regs [2**REG_ADDR_WIDTH];
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic [ISA_WIDTH-1:0]      rs_val;
    logic [ISA_WIDTH-1:0]      rt_val;
    logic [ISA_WIDTH-1:0]      imm_ext;
    alu_op_t                   alu_op;
    logic                      use_imm;
    logic                      zero_ext;   // ori only
    logic                      uses_rt;    // rt is a source, not the dest
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      branch;
    logic                      bubble;

    assign rs = id_instr.i.rs;
    assign rt = id_instr.i.rt;

    // control decode
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        uses_rt   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        dest      = id_instr.i.rt;  // i-type writes rt
        case (id_instr.r.opcode)
            OP_RTYPE: begin
                use_imm   = 1'b0;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                dest      = id_instr.r.rd;
                case (id_instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;  // unknown funct acts as nop
                endcase
            end
            OP_ADDIU: reg_write = 1'b1;
            OP_ORI: begin
                alu_op    = ALU_OR;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_SW: begin
                mem_write = 1'b1;
                uses_rt   = 1'b1;  // store data
            end
            OP_BEQ: begin
                alu_op  = ALU_SUB;  // zero result means equal
                use_imm = 1'b0;
                uses_rt = 1'b1;
                branch  = 1'b1;
            end
            default: ;
        endcase
    end

    assign imm_ext = zero_ext ? {16'b0, id_instr.i.imm} : {{16{id_instr.i.imm[15]}}, id_instr.i.imm};

    // register file, r0 never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 2**REG_ADDR_WIDTH; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_reg_write && wb_dest != '0 && !out_stall) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // reads with write-through from wb
    always_comb begin
        rs_val = regs[rs];
        rt_val = regs[rt];
        if (wb_reg_write && wb_dest == rs) rs_val = wb_data;
        if (wb_reg_write && wb_dest == rt) rt_val = wb_data;
        if (rs == '0) rs_val = '0;
        if (rt == '0) rt_val = '0;
    end

    // load in ex feeding this instruction, hold one cycle
    assign hazard_stall = id_valid && ex_valid && ex_mem_read && ex_dest != '0 &&
                          (ex_dest == rs || (uses_rt && ex_dest == rt));

    assign bubble = branch_taken || hazard_stall || !id_valid;

    // id/ex control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
        end else if (!out_stall) begin
            ex_valid     <= !bubble;
            ex_reg_write <= !bubble && reg_write;
            ex_mem_read  <= !bubble && mem_read;
            ex_mem_write <= !bubble && mem_write;
            ex_branch    <= !bubble && branch;
        end
    end

    // id/ex payload
    always_ff @(posedge clk) begin
        if (!out_stall) begin
            ex_alu_op    <= alu_op;
            ex_operand_a <= rs_val;
            ex_operand_b <= rt_val;
            ex_imm       <= imm_ext;
            ex_use_imm   <= use_imm;
            ex_rs        <= rs;
            ex_rt        <= rt;
            ex_dest      <= dest;
            ex_pc_plus4  <= id_pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       out_stall,
    input  wire alu_op_t              ex_alu_op,
    input  wire [ISA_WIDTH-1:0]       ex_operand_a,
    input  wire [ISA_WIDTH-1:0]       ex_operand_b,
    input  wire [ISA_WIDTH-1:0]       ex_imm,
    input  wire                       ex_use_imm,
    input  wire [REG_ADDR_WIDTH-1:0]  ex_rs,
    input  wire [REG_ADDR_WIDTH-1:0]  ex_rt,
    input  wire [REG_ADDR_WIDTH-1:0]  ex_dest,
    input  wire                       ex_reg_write,
    input  wire                       ex_mem_read,
    input  wire                       ex_mem_write,
    input  wire                       ex_branch,
    input  wire [ISA_WIDTH-1:0]       ex_pc_plus4,
    input  wire                       ex_valid,
    input  wire [ISA_WIDTH-1:0]       wb_data,
    input  wire [REG_ADDR_WIDTH-1:0]  wb_dest,
    input  wire                       wb_reg_write,
    output logic                      branch_taken,
    output logic [ISA_WIDTH-1:0]      branch_target,
    output logic [ISA_WIDTH-1:0]      mem_result,
    output logic [ISA_WIDTH-1:0]      mem_store_data,
    output logic [REG_ADDR_WIDTH-1:0] mem_dest,
    output logic                      mem_reg_write,
    output logic                      mem_mem_read,
    output logic                      mem_mem_write,
    output logic                      mem_valid
);

    fwd_sel_t             sel_a;
    fwd_sel_t             sel_b;
    logic [ISA_WIDTH-1:0] src_a;
    logic [ISA_WIDTH-1:0] src_b;   // rt after forwarding, also store data
    logic [ISA_WIDTH-1:0] alu_b;
    logic [ISA_WIDTH-1:0] alu_y;

    // newest producer wins, r0 never forwarded
    function automatic fwd_sel_t fwd_select(input logic [REG_ADDR_WIDTH-1:0] src);
        fwd_sel_t sel;
        if (src != '0 && mem_valid && mem_reg_write && mem_dest == src) begin
            sel = FWD_MEM;
        end else if (src != '0 && wb_reg_write && wb_dest == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        sel_a = fwd_select(ex_rs);
        sel_b = fwd_select(ex_rt);
        case (sel_a)
            FWD_MEM: src_a = mem_result;
            FWD_WB:  src_a = wb_data;
            default: src_a = ex_operand_a;
        endcase
        case (sel_b)
            FWD_MEM: src_b = mem_result;
            FWD_WB:  src_b = wb_data;
            default: src_b = ex_operand_b;
        endcase
    end

    assign alu_b = ex_use_imm ? ex_imm : src_b;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_y = src_a + alu_b;
            ALU_SUB: alu_y = src_a - alu_b;
            ALU_AND: alu_y = src_a & alu_b;
            ALU_OR:  alu_y = src_a | alu_b;
            ALU_SLT: alu_y = {{(ISA_WIDTH-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
            default: alu_y = '0;
        endcase
    end

    // beq resolved here, target is pc+4 plus word offset
    assign branch_taken  = ex_valid && ex_branch && alu_y == '0;
    assign branch_target = ex_pc_plus4 + {ex_imm[ISA_WIDTH-3:0], 2'b00};

    // ex/mem control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else if (!out_stall) begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    // ex/mem payload
    always_ff @(posedge clk) begin
        if (!out_stall) begin
            mem_result     <= alu_y;
            mem_store_data <= src_b;
            mem_dest       <= ex_dest;
        end
    end

endmodule

`default_nettype wire

/* hdl/instruction_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_mem import cpu_pkg::*; (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       run,
    input  wire                       load_req,
    input  wire [IMEM_ADDR_WIDTH-1:0] load_addr,
    input  wire [ISA_WIDTH-1:0]       load_data,
    input  wire                       hazard_stall,  // load-use, hold pc and if/id
    input  wire                       out_stall,     // output port busy, freeze
    input  wire                       branch_taken,
    input  wire [ISA_WIDTH-1:0]       branch_target,
    output logic                      load_ack,
    output instr_t                    id_instr,
    output logic [ISA_WIDTH-1:0]      id_pc_plus4,
    output logic                      id_valid
);

    logic [ISA_WIDTH-1:0] imem [IMEM_DEPTH];  // program store
    logic [ISA_WIDTH-1:0] pc;
    logic [ISA_WIDTH-1:0] pc_plus4;
    logic                 load_wr;  // one write per req
    logic                 advance;  // fetch may move this cycle

    assign pc_plus4 = pc + 32'd4;
    assign load_wr  = !run && load_req && !load_ack;  // host only while halted
    assign advance  = run && !out_stall;

    // load handshake, ack one cycle after req seen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_ack <= 1'b0;
        end else if (load_wr) begin
            load_ack <= 1'b1;
        end else if (!load_req) begin
            load_ack <= 1'b0;  // req dropped, release
        end
    end

    always_ff @(posedge clk) begin
        if (load_wr) begin
            imem[load_addr] <= load_data;
        end
    end

    // pc, branch wins over the load-use hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (advance) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (!hazard_stall) begin
                pc <= pc_plus4;
            end
        end
    end

    // if/id valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else if (advance) begin
            if (branch_taken) begin
                id_valid <= 1'b0;  // younger fetch squashed
            end else if (!hazard_stall) begin
                id_valid <= 1'b1;
            end
        end
    end

    // if/id payload, word index from pc[7:2]
    always_ff @(posedge clk) begin
        if (advance && !hazard_stall) begin
            id_instr    <= imem[pc[IMEM_ADDR_WIDTH+1:2]];
            id_pc_plus4 <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* tests/cpu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts import cpu_pkg::*; (
    input wire                       clk,
    input wire                       arst_n,
    input wire                       run,
    input wire                       load_req,
    input wire                       load_ack,
    input wire                       out_req,
    input wire                       out_ack,
    input wire [ISA_WIDTH-1:0]       out_data
);

    int fail_count = 0;  // failed assertions

    // ack only answers a request made while halted
    load_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(load_ack) |-> $past(load_req) && !$past(run))
        else begin
            fail_count++;
            $error("load_ack rose without a load request while halted");
        end

    load_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(load_ack) |-> !$past(load_req))
        else begin
            fail_count++;
            $error("load_ack fell while load_req was still high");
        end

    // req held until the host acks
    out_req_release: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(out_req) |-> $past(out_ack))
        else begin
            fail_count++;
            $error("out_req fell before out_ack rose");
        end

    out_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && $past(out_req) |-> $stable(out_data))
        else begin
            fail_count++;
            $error("out_data changed while out_req was high");
        end

endmodule

bind cpu_top cpu_asserts cpu_asserts_i (
    .clk(clk),
    .arst_n(arst_n),
    .run(run),
    .load_req(load_req),
    .load_ack(load_ack),
    .out_req(out_req),
    .out_ack(out_ack),
    .out_data(out_data)
);

`default_nettype wire

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int          WAIT_LIMIT = 300;           // cycles allowed per wait
    localparam int          QUIET_TIME = 60;            // cycles watched after the marker
    localparam logic [31:0] MARKER     = 32'h0000_c0de; // last value the program sends

    logic                       clk;
    logic                       arst_n;
    logic                       run;
    logic                       load_req;
    logic [IMEM_ADDR_WIDTH-1:0] load_addr;
    logic [ISA_WIDTH-1:0]       load_data;
    logic                       out_ack;
    logic                       load_ack;
    logic                       out_req;
    logic [ISA_WIDTH-1:0]       out_data;

    logic [ISA_WIDTH-1:0] program_words [$];
    logic [ISA_WIDTH-1:0] expected_q [$];   // output values still to come in order
    int                   errors;
    int                   timeouts;

    cpu_top cpu_top_i (
        .clk(clk), .arst_n(arst_n), .run(run),
        .load_req(load_req), .load_addr(load_addr), .load_data(load_data),
        .out_ack(out_ack),
        .load_ack(load_ack), .out_req(out_req), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encode_rtype(input logic [5:0] funct, input int rd,
                                                 input int rs, input int rt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input int rt,
                                                 input int rs, input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic build_program();
        program_words = {};
        program_words.push_back(encode_itype(OP_ORI,   1, 0, OUT_ADDR[15:0])); // $1 port addr
        program_words.push_back(encode_itype(OP_ADDIU, 2, 0, 16'd5));
        program_words.push_back(encode_itype(OP_ADDIU, 3, 2, 16'hfff0));  // fwd from mem
        program_words.push_back(encode_rtype(FN_ADDU,  4, 2, 3));         // mem and wb fwd
        program_words.push_back(encode_itype(OP_SW,    4, 1, 16'd0));
        program_words.push_back(encode_rtype(FN_SUBU,  5, 2, 3));
        program_words.push_back(encode_rtype(FN_AND,   6, 4, 3));
        program_words.push_back(encode_rtype(FN_OR,    7, 5, 2));
        program_words.push_back(encode_rtype(FN_SLT,   8, 3, 2));         // true when signed
        program_words.push_back(encode_rtype(FN_SLT,   9, 2, 3));         // false
        program_words.push_back(encode_itype(OP_ORI,   10, 0, 16'h8001));
        program_words.push_back(encode_itype(OP_ADDIU, 11, 0, 16'h8001));
        for (int r = 5; r <= 11; r++) begin
            program_words.push_back(encode_itype(OP_SW, r, 1, 16'd0));   // words 12..18
        end
        program_words.push_back(encode_itype(OP_SW,    7, 0, 16'd8));     // data word 2
        program_words.push_back(encode_itype(OP_LW,    13, 0, 16'd8));
        program_words.push_back(encode_itype(OP_ADDIU, 14, 13, 16'd1));   // load-use
        program_words.push_back(encode_itype(OP_SW,    14, 1, 16'd0));
        program_words.push_back(encode_itype(OP_BEQ,   9, 8, 16'd2));     // not taken
        program_words.push_back(encode_itype(OP_SW,    2, 1, 16'd0));
        program_words.push_back(encode_itype(OP_BEQ,   7, 13, 16'd2));    // taken
        program_words.push_back(encode_itype(OP_SW,    3, 1, 16'd0));     // skipped
        program_words.push_back(encode_itype(OP_SW,    4, 1, 16'd0));     // skipped
        program_words.push_back(encode_itype(OP_ORI,   15, 0, MARKER[15:0]));
        program_words.push_back(encode_itype(OP_SW,    15, 1, 16'd0));
        program_words.push_back(encode_itype(OP_BEQ,   0, 0, 16'hffff));  // spin here
    endtask

    // register values by mips rules in program order
    task automatic build_expected();
        logic [31:0] r2, r3, r4, r5, r6, r7, r8, r9, r14;
        r2  = 32'd5;
        r3  = r2 - 32'd16;                  // imm 16'hfff0 is -16
        r4  = r2 + r3;
        r5  = r2 - r3;
        r6  = r4 & r3;
        r7  = r5 | r2;
        r8  = (int'(r3) < int'(r2)) ? 32'd1 : 32'd0;
        r9  = (int'(r2) < int'(r3)) ? 32'd1 : 32'd0;
        r14 = r7 + 32'd1;                   // $13 reloads $7 from memory
        // ori zero-extends and addiu sign-extends 16'h8001
        expected_q = {r4, r5, r6, r7, r8, r9, 32'h0000_8001, 32'hffff_8001,
                      r14, r2, MARKER};
    endtask

    task automatic wait_load_ack(input logic level);
        int n;
        n = 0;
        while (timeouts == 0 && load_ack !== level) begin
            @(posedge clk);
            n++;
            if (n >= WAIT_LIMIT && load_ack !== level) begin
                timeouts++;
                $display("timed out waiting for load_ack to become %0b", level);
            end
        end
    endtask

    task automatic wait_out_req(input logic level);
        int n;
        n = 0;
        while (timeouts == 0 && out_req !== level) begin
            @(posedge clk);
            n++;
            if (n >= WAIT_LIMIT && out_req !== level) begin
                timeouts++;
                $display("timed out waiting for out_req to become %0b", level);
            end
        end
    endtask

    // one four-phase write into instruction memory
    task automatic load_word(input logic [IMEM_ADDR_WIDTH-1:0] addr,
                             input logic [ISA_WIDTH-1:0] data);
        if (timeouts == 0) begin
            load_addr <= addr;
            load_data <= data;
            load_req  <= 1'b1;
            wait_load_ack(1'b1);
            load_req  <= 1'b0;
            wait_load_ack(1'b0);
        end
    endtask

    // take one value from the port after a random ack delay
    task automatic accept_output();
        logic [ISA_WIDTH-1:0] expected;
        int unsigned          delay;
        wait_out_req(1'b1);
        if (timeouts == 0) begin
            delay    = $urandom % 4;
            expected = expected_q.pop_front();
            repeat (delay) @(posedge clk);
            out_data_match: assert (out_data == expected) else begin
                errors++;
                $display("error: out_data is %h, expected %h", out_data, expected);
            end
            out_ack <= 1'b1;
            wait_out_req(1'b0);
            out_ack <= 1'b0;
        end
    endtask

    // port stays idle while the program spins
    task automatic watch_quiet();
        repeat (QUIET_TIME) begin
            @(posedge clk);
            no_extra_output: assert (out_req !== 1'b1) else begin
                errors++;
                $display("output request seen after the end marker, out_data %h", out_data);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h51bb_32f4));
        errors    = 0;
        timeouts  = 0;
        arst_n    <= 1'b0;
        run       <= 1'b0;  // halted while loading
        load_req  <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        out_ack   <= 1'b0;
        build_program();
        build_expected();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        reset_idle: assert (!load_ack && !out_req) else begin
            errors++;
            $display("load_ack or out_req not low after reset");
        end
        foreach (program_words[k]) begin
            load_word(IMEM_ADDR_WIDTH'(k), program_words[k]);
        end
        run <= 1'b1;
        while (expected_q.size() > 0 && timeouts == 0) begin
            accept_output();
        end
        if (timeouts == 0) begin
            load_req <= 1'b1;  // host request while running gets no ack
            watch_quiet();
            load_req <= 1'b0;
        end
        $display("value errors: %0d, timeouts: %0d, protocol assertion failures: %0d",
                 errors, timeouts, cpu_top_i.cpu_asserts_i.fail_count);
        if (errors == 0 && timeouts == 0 && cpu_top_i.cpu_asserts_i.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
